/* project.f */
+incdir+logic
logic/nn_engine_pkg.sv
logic/nn_csb_apb.sv
logic/nn_window_feeder.sv
logic/nn_lane.sv
logic/nn_writeback.sv
logic/nn_engine_top.sv
verif/nn_engine_properties.sv
verif/nn_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= nn_engine_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG := >>> FAIL
PASS_MSG := >>> PASS
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/nn_engine_tb.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_engine_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import nn_engine_pkg::*;

	localparam int DEPTH = 1 << `NN_ADDR_W;

	logic                        clk;
	logic                        rst;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [7:0]                  paddr;
	logic [31:0]                 pwdata;
	logic [31:0]                 prdata;
	logic                        pready;
	logic                        pslverr;
	logic [`NN_ADDR_W-1:0]       data_addr;
	logic [`NN_ADDR_W-1:0]       weight_addr;
	logic [`NN_LANES*`NN_DW-1:0] ram_data = '0;
	logic [`NN_LANES*`NN_DW-1:0] ram_weight = '0;
	logic                        out_valid;
	logic [`NN_DW-1:0]           out_data;
	logic [15:0]                 out_index;
	logic                        irq;

	logic [`NN_LANES*`NN_DW-1:0] data_mem [DEPTH];
	logic [`NN_LANES*`NN_DW-1:0] weight_mem [DEPTH];
	logic [`NN_DW-1:0]           got_data [$];
	logic [15:0]                 got_index [$];
	logic [`NN_DW-1:0]           exp_data [$];  // reference model results

	nn_engine_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.i_psel        (psel),
		.i_penable     (penable),
		.i_pwrite      (pwrite),
		.i_paddr       (paddr),
		.i_pwdata      (pwdata),
		.o_prdata      (prdata),
		.o_pready      (pready),
		.o_pslverr     (pslverr),
		.o_data_addr   (data_addr),
		.o_weight_addr (weight_addr),
		.i_data        (ram_data),
		.i_weight      (ram_weight),
		.o_out_valid   (out_valid),
		.o_out_data    (out_data),
		.o_out_index   (out_index),
		.o_irq         (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// single port rams with one cycle read latency
	always @(posedge clk) begin
		ram_data   <= data_mem[data_addr];
		ram_weight <= weight_mem[weight_addr];
	end

	always @(negedge clk) begin
		if (out_valid) begin
			got_data.push_back(out_data);
			got_index.push_back(out_index);
		end
	end

	function automatic int run_cycles(input int count, input int kernel);
		return count * (kernel + `NN_LANES + 8) + 40;  // drain gap plus apb setup
	endfunction

	function automatic int sample_at(input int addr, input int lane);
		logic [`NN_DW-1:0] raw;
		raw = data_mem[addr][lane*`NN_DW +: `NN_DW];
		return int'($signed(raw));
	endfunction

	function automatic int weight_at(input int addr, input int lane);
		logic [`NN_DW-1:0] raw;
		raw = weight_mem[addr][lane*`NN_DW +: `NN_DW];
		return int'($signed(raw));
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input logic [`NN_DW-1:0] got, input logic [`NN_DW-1:0] exp,
			input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic apb_transfer(input logic is_write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;  // setup phase
		penable <= 1'b0;
		pwrite  <= is_write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);  // mid access phase
		rdata = prdata;
		err   = pslverr;
		check_bit(pready, 1'b1, "pready in the access phase");
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(1'b1, addr, data, rdata, err);
		check_bit(err, 1'b0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_transfer(1'b0, addr, 32'd0, data, err);
		check_bit(err, 1'b0, $sformatf("pslverr on read of %h", addr));
	endtask

	task automatic fill_memories();
		void'($urandom(32'h49d3_c10a));
		for (int a = 0; a < DEPTH; a++) begin
			for (int l = 0; l < `NN_LANES; l++) begin
				data_mem[a][l*`NN_DW +: `NN_DW]   = 16'($urandom_range(4095)) - 16'd2048;
				weight_mem[a][l*`NN_DW +: `NN_DW] = 16'($urandom_range(15)) - 16'd8;
			end
		end
	endtask

	// window w, beat b reads data at w*stride+b and weight at b
	task automatic build_expected(input nn_op_e op, input int kernel, input int stride,
			input int count, input logic [15:0] bias);
		int addr;
		int sum;
		int peak;
		int total;
		exp_data.delete();
		for (int w = 0; w < count; w++) begin
			total = int'($signed(bias));
			for (int l = 0; l < `NN_LANES; l++) begin
				sum  = 0;
				peak = sample_at(w * stride, l);
				for (int b = 0; b < kernel; b++) begin
					addr = w * stride + b;
					if (op == OP_CONV)
						sum += sample_at(addr, l) * weight_at(b, l);
					else
						sum += sample_at(addr, l);
					if (sample_at(addr, l) > peak)
						peak = sample_at(addr, l);
				end
				total += sum;
				if (op == OP_MAXPOOL)
					exp_data.push_back(16'(peak));
				else if (op == OP_AVEPOOL)
					exp_data.push_back(16'(sum / kernel));  // truncates toward zero
			end
			if (op == OP_CONV) begin
				if (total < 0)
					total = 0;  // relu
				else if (total > 32767)
					total = 32767;
				exp_data.push_back(16'(total));
			end
		end
	endtask

	// polls the sticky done bit in STATUS
	task automatic wait_done();
		logic [31:0] status;
		do
			read_reg(`NN_REG_STATUS, status);
		while (status[1] !== 1'b1);
	endtask

	task automatic run_layer(input nn_op_e op, input int kernel, input int stride,
			input int count, input logic [15:0] bias, input bit restart);
		logic [31:0] ctrl;
		logic [31:0] value;
		ctrl = {27'd0, 1'b1, 2'd0, op};  // start in bit 4
		write_reg(`NN_REG_KERNEL, 32'(kernel));
		write_reg(`NN_REG_STRIDE, 32'(stride));
		write_reg(`NN_REG_COUNT, 32'(count));
		write_reg(`NN_REG_BIAS, {16'd0, bias});
		build_expected(op, kernel, stride, count, bias);
		got_data.delete();
		got_index.delete();
		write_reg(`NN_REG_CTRL, ctrl);
		if (restart)
			write_reg(`NN_REG_CTRL, ctrl);  // lands while busy
		read_reg(`NN_REG_STATUS, value);
		check_reg(value, 32'h1, "status while running");
		wait_done();
		check_bit(irq, 1'b1, "irq after run");
		read_reg(`NN_REG_STATUS, value);
		check_reg(value, 32'h2, "status after run");
		read_reg(`NN_REG_CYCLES, value);
		check_bit(value != 32'd0, 1'b1, "cycle counter nonzero");
		check_word(16'(got_data.size()), 16'(exp_data.size()), "output count");
		foreach (exp_data[k]) begin
			check_word(got_data[k], exp_data[k], $sformatf("output %0d data", k));
			check_word(got_index[k], 16'(k), $sformatf("output %0d index", k));
		end
	endtask

	task automatic register_access();
		logic [31:0] value;
		logic        err;
		read_reg(`NN_REG_STATUS, value);
		check_reg(value, 32'h0, "status after reset");
		read_reg(`NN_REG_CYCLES, value);
		check_reg(value, 32'h0, "cycles after reset");
		write_reg(`NN_REG_KERNEL, 32'h0000_01a5);
		read_reg(`NN_REG_KERNEL, value);
		check_reg(value, 32'h0000_00a5, "kernel readback");
		write_reg(`NN_REG_STRIDE, 32'h0000_003c);
		read_reg(`NN_REG_STRIDE, value);
		check_reg(value, 32'h0000_003c, "stride readback");
		write_reg(`NN_REG_COUNT, 32'h0000_ff07);
		read_reg(`NN_REG_COUNT, value);
		check_reg(value, 32'h0000_0007, "count readback");
		write_reg(`NN_REG_BIAS, 32'h1234_8001);
		read_reg(`NN_REG_BIAS, value);
		check_reg(value, 32'h0000_8001, "bias readback");
		apb_transfer(1'b0, 8'h1c, 32'd0, value, err);
		check_bit(err, 1'b1, "pslverr on unmapped read");
		apb_transfer(1'b1, 8'h40, 32'hdead_beef, value, err);
		check_bit(err, 1'b1, "pslverr on unmapped write");
	endtask

	task automatic conv_layers();
		run_layer(OP_CONV, 3, 1, 5, 16'(10000), 1'b0);
		run_layer(OP_CONV, 3, 1, 5, 16'(-5000), 1'b0);
	endtask

	task automatic maxpool_layer();
		run_layer(OP_MAXPOOL, 2, 2, 4, 16'd0, 1'b0);
	endtask

	task automatic avepool_layer();
		run_layer(OP_AVEPOOL, 3, 3, 4, 16'd0, 1'b0);
	endtask

	task automatic back_to_back_windows();
		run_layer(OP_MAXPOOL, 1, 1, 20, 16'd0, 1'b0);
	endtask

	task automatic done_and_restart();
		run_layer(OP_AVEPOOL, 2, 1, 6, 16'd0, 1'b1);
	endtask

	initial begin : watchdog
		int budget;
		budget = 2 * run_cycles(5, 3) + run_cycles(4, 2) + run_cycles(4, 3) +
		         run_cycles(20, 1) + run_cycles(6, 2) + 200;
		repeat (budget) @(posedge clk);
		abort_run("timeout: the tests did not complete within the cycle budget");
	end

	initial begin
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'd0;
		pwdata  = 32'd0;
		fill_memories();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		register_access();
		conv_layers();
		maxpool_layer();
		avepool_layer();
		back_to_back_windows();
		done_and_restart();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/nn_engine_properties.sv */
`default_nettype none

module nn_engine_properties (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_psel,
	input  logic                        i_penable,
	input  logic                        i_pready,
	input  logic                        i_wb_busy,
	input  logic                        i_beat_last,
	input  logic                        i_out_valid,
	input  nn_engine_pkg::feed_state_e  i_feed_state
);
	timeunit 1ns;
	timeprecision 1ps;
	import nn_engine_pkg::*;

	// zero wait state slave
	a_pready: assert property (@(posedge clk) disable iff (rst)
		(i_psel && i_penable) |-> i_pready)
		else $error("pready low during an apb access phase");

	// beat_last trails the issue by one cycle
	a_hazard: assert property (@(posedge clk) disable iff (rst)
		i_wb_busy |=> !i_beat_last)
		else $error("last beat issued while writeback busy");

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(i_feed_state == FS_IDLE) |-> !i_out_valid)
		else $error("output valid while sequencer idle");

endmodule

bind nn_engine_top nn_engine_properties u_props (
	.clk          (clk),
	.rst          (rst),
	.i_psel       (i_psel),
	.i_penable    (i_penable),
	.i_pready     (o_pready),
	.i_wb_busy    (wb_busy),
	.i_beat_last  (beat_last),
	.i_out_valid  (o_out_valid),
	.i_feed_state (u_feeder.state)
);

`default_nettype wire

/* logic/nn_engine_top.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_engine_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_psel,
	input  logic                        i_penable,
	input  logic                        i_pwrite,
	input  logic [7:0]                  i_paddr,
	input  logic [31:0]                 i_pwdata,
	output logic [31:0]                 o_prdata,
	output logic                        o_pready,
	output logic                        o_pslverr,
	output logic [`NN_ADDR_W-1:0]       o_data_addr,
	output logic [`NN_ADDR_W-1:0]       o_weight_addr,
	input  logic [`NN_LANES*`NN_DW-1:0] i_data,
	input  logic [`NN_LANES*`NN_DW-1:0] i_weight,
	output logic                        o_out_valid,
	output logic [`NN_DW-1:0]           o_out_data,
	output logic [15:0]                 o_out_index,
	output logic                        o_irq
);
	import nn_engine_pkg::*;

	nn_op_e                      op;
	logic                        start;
	logic                        done;
	logic [7:0]                  kernel;
	logic [7:0]                  stride;
	logic [7:0]                  count;
	logic [15:0]                 bias;
	logic                        wb_busy;
	logic                        beat_valid;
	logic                        beat_first;
	logic                        beat_last;
	logic [`NN_LANES-1:0]        lane_valid;  // lanes run in lockstep
	logic [`NN_LANES*`NN_AW-1:0] lane_res;

	nn_csb_apb u_csb (
		.clk       (clk),
		.rst       (rst),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.i_done    (done),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_start   (start),
		.o_op      (op),
		.o_kernel  (kernel),
		.o_stride  (stride),
		.o_count   (count),
		.o_bias    (bias),
		.o_irq     (o_irq)
	);

	nn_window_feeder u_feeder (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start),
		.i_kernel      (kernel),
		.i_stride      (stride),
		.i_count       (count),
		.i_wb_busy     (wb_busy),
		.o_data_addr   (o_data_addr),
		.o_weight_addr (o_weight_addr),
		.o_beat_valid  (beat_valid),
		.o_beat_first  (beat_first),
		.o_beat_last   (beat_last),
		.o_done        (done)
	);

	for (genvar g = 0; g < `NN_LANES; g++) begin : gen_lane
		nn_lane u_lane (
			.clk          (clk),
			.rst          (rst),
			.i_op         (op),
			.i_beat_valid (beat_valid),
			.i_beat_first (beat_first),
			.i_beat_last  (beat_last),
			.i_data       (i_data[g*`NN_DW +: `NN_DW]),
			.i_weight     (i_weight[g*`NN_DW +: `NN_DW]),
			.o_res_valid  (lane_valid[g]),
			.o_res        (lane_res[g*`NN_AW +: `NN_AW])
		);
	end

	nn_writeback u_wb (
		.clk         (clk),
		.rst         (rst),
		.i_op        (op),
		.i_kernel    (kernel),
		.i_bias      (bias),
		.i_start     (start),
		.i_res_valid (lane_valid[0]),
		.i_res       (lane_res),
		.o_wb_busy   (wb_busy),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_out_index (o_out_index)
	);

endmodule

`default_nettype wire

/* logic/nn_writeback.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_writeback (
	input  logic                        clk,
	input  logic                        rst,
	input  nn_engine_pkg::nn_op_e       i_op,
	input  logic [7:0]                  i_kernel,
	input  logic [`NN_DW-1:0]           i_bias,
	input  logic                        i_start,
	input  logic                        i_res_valid,
	input  logic [`NN_LANES*`NN_AW-1:0] i_res,
	output logic                        o_wb_busy,
	output logic                        o_out_valid,
	output logic [`NN_DW-1:0]           o_out_data,
	output logic [15:0]                 o_out_index
);
	import nn_engine_pkg::*;

	localparam int SW   = `NN_AW + 4;  // headroom for the cross-lane sum
	localparam int SELW = (`NN_LANES > 1) ? $clog2(`NN_LANES) : 1;
	localparam logic signed [SW-1:0] SAT_MAX = SW'((1 << (`NN_DW - 1)) - 1);

	logic [`NN_LANES*`NN_AW-1:0] res_q;
	logic                        pend;  // captured with words left to emit
	logic [SELW-1:0]             sel;
	logic                        sel_last;
	logic signed [SW-1:0]        conv_sum;
	logic signed [`NN_AW-1:0]    lane_res;
	logic signed [`NN_AW-1:0]    lane_avg;
	logic [`NN_DW-1:0]           out_nxt;

	always_comb begin
		conv_sum = SW'($signed(i_bias));
		for (int i = 0; i < `NN_LANES; i++)
			conv_sum = conv_sum + SW'($signed(res_q[i*`NN_AW +: `NN_AW]));
	end

	assign lane_res = res_q[sel*`NN_AW +: `NN_AW];
	assign lane_avg = lane_res / $signed({1'b0, i_kernel});  // truncates toward zero

	// conv emits a single word, pooling one per lane
	assign sel_last = (i_op != OP_MAXPOOL && i_op != OP_AVEPOOL) ||
	                  (sel == SELW'(`NN_LANES - 1));

	always_comb begin
		case (i_op)
			OP_CONV: begin
				if (conv_sum < 0)
					out_nxt = '0;  // relu
				else if (conv_sum > SAT_MAX)
					out_nxt = SAT_MAX[`NN_DW-1:0];
				else
					out_nxt = conv_sum[`NN_DW-1:0];
			end
			OP_MAXPOOL: out_nxt = lane_res[`NN_DW-1:0];
			OP_AVEPOOL: out_nxt = lane_avg[`NN_DW-1:0];
			default:    out_nxt = '0;
		endcase
	end

	assign o_wb_busy = pend | o_out_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend        <= 1'b0;
			sel         <= '0;
			o_out_valid <= 1'b0;
			o_out_index <= 16'd0;
		end else begin
			o_out_valid <= 1'b0;
			if (i_res_valid) begin
				pend <= 1'b1;
				sel  <= '0;
			end else if (pend) begin
				o_out_valid <= 1'b1;
				if (sel_last)
					pend <= 1'b0;
				else
					sel <= sel + 1'b1;
			end
			if (i_start)
				o_out_index <= 16'd0;
			else if (o_out_valid)
				o_out_index <= o_out_index + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_res_valid)
			res_q <= i_res;
		if (pend)
			o_out_data <= out_nxt;
	end

endmodule

`default_nettype wire

/* logic/nn_lane.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_lane (
	input  logic                  clk,
	input  logic                  rst,
	input  nn_engine_pkg::nn_op_e i_op,
	input  logic                  i_beat_valid,
	input  logic                  i_beat_first,
	input  logic                  i_beat_last,
	input  logic [`NN_DW-1:0]     i_data,
	input  logic [`NN_DW-1:0]     i_weight,
	output logic                  o_res_valid,
	output logic [`NN_AW-1:0]     o_res
);
	import nn_engine_pkg::*;

	logic signed [`NN_AW-1:0] acc;
	logic signed [`NN_AW-1:0] acc_nxt;
	logic signed [`NN_AW-1:0] sample;  // sign extended data
	logic signed [`NN_AW-1:0] prod;
	logic signed [`NN_AW-1:0] base;

	assign sample = {{(`NN_AW - `NN_DW){i_data[`NN_DW-1]}}, i_data};
	assign prod   = $signed(i_data) * $signed(i_weight);
	assign base   = i_beat_first ? '0 : acc;  // first beat reloads

	always_comb begin
		case (i_op)
			OP_CONV:    acc_nxt = base + prod;
			OP_AVEPOOL: acc_nxt = base + sample;
			OP_MAXPOOL: acc_nxt = (i_beat_first || sample > acc) ? sample : acc;
			default:    acc_nxt = acc;
		endcase
	end

	// result register frees the accumulator for the next window
	always_ff @(posedge clk) begin
		if (i_beat_valid) begin
			acc <= acc_nxt;
			if (i_beat_last)
				o_res <= acc_nxt;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= i_beat_valid & i_beat_last;
	end

endmodule

`default_nettype wire

/* logic/nn_window_feeder.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_window_feeder (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	input  logic [7:0]            i_kernel,
	input  logic [7:0]            i_stride,
	input  logic [7:0]            i_count,
	input  logic                  i_wb_busy,
	output logic [`NN_ADDR_W-1:0] o_data_addr,
	output logic [`NN_ADDR_W-1:0] o_weight_addr,
	output logic                  o_beat_valid,
	output logic                  o_beat_first,
	output logic                  o_beat_last,
	output logic                  o_done
);
	import nn_engine_pkg::*;

	feed_state_e           state;
	logic [7:0]            beat_cnt;
	logic [7:0]            win_cnt;
	logic [`NN_ADDR_W-1:0] win_base;  // first data address of the window
	logic                  last_d2;   // last beat issued two cycles ago
	logic                  is_last;
	logic                  stall;
	logic                  issue;

	assign is_last = (beat_cnt == i_kernel - 8'd1);

	// o_beat_last is the last beat issued one cycle ago, so with last_d2 it
	// covers the gap until the writeback raises i_wb_busy
	assign stall = is_last & (i_wb_busy | o_beat_last | last_d2);
	assign issue = (state == FS_RUN) & ~stall;

	assign o_data_addr   = win_base + `NN_ADDR_W'(beat_cnt);
	assign o_weight_addr = `NN_ADDR_W'(beat_cnt);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= FS_IDLE;
			beat_cnt <= 8'd0;
			win_cnt  <= 8'd0;
			win_base <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				FS_IDLE: begin
					if (i_start) begin
						state    <= FS_RUN;
						beat_cnt <= 8'd0;
						win_cnt  <= 8'd0;
						win_base <= '0;
					end
				end
				FS_RUN: begin
					if (issue) begin
						if (is_last) begin
							beat_cnt <= 8'd0;
							win_base <= win_base + `NN_ADDR_W'(i_stride);
							if (win_cnt == i_count - 8'd1)
								state <= FS_FLUSH;
							else
								win_cnt <= win_cnt + 8'd1;
						end else begin
							beat_cnt <= beat_cnt + 8'd1;
						end
					end
				end
				FS_FLUSH: begin
					// final results captured and drained
					if (!o_beat_last && !last_d2 && !i_wb_busy) begin
						o_done <= 1'b1;
						state  <= FS_IDLE;
					end
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	// flags trail the address by the ram read latency
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_beat_valid <= 1'b0;
			o_beat_first <= 1'b0;
			o_beat_last  <= 1'b0;
			last_d2      <= 1'b0;
		end else begin
			o_beat_valid <= issue;
			o_beat_first <= issue & (beat_cnt == 8'd0);
			o_beat_last  <= issue & is_last;
			last_d2      <= o_beat_last;
		end
	end

endmodule

`default_nettype wire

/* logic/nn_csb_apb.sv */
`default_nettype none
`include "nn_engine_defs.svh"

module nn_csb_apb (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [7:0]            i_paddr,
	input  logic [31:0]           i_pwdata,
	input  logic                  i_done,
	output logic [31:0]           o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,
	output logic                  o_start,
	output nn_engine_pkg::nn_op_e o_op,
	output logic [7:0]            o_kernel,
	output logic [7:0]            o_stride,
	output logic [7:0]            o_count,
	output logic [15:0]           o_bias,
	output logic                  o_irq
);
	import nn_engine_pkg::*;

	logic        access;
	logic        wr_en;
	logic        mapped;
	logic        start_req;
	logic        busy;
	logic        done;  // sticky until the next start
	logic [31:0] cycles;

	assign access    = i_psel & i_penable;
	assign wr_en     = access & i_pwrite;
	assign start_req = wr_en & (i_paddr == `NN_REG_CTRL) & i_pwdata[4] & ~busy;
	assign o_pready  = 1'b1;  // zero wait states
	assign o_pslverr = access & ~mapped;
	assign o_irq     = done;

	// read mux decoded during the access phase
	always_comb begin
		mapped   = 1'b1;
		o_prdata = 32'd0;
		case (i_paddr)
			`NN_REG_CTRL:   o_prdata = {30'd0, o_op};
			`NN_REG_KERNEL: o_prdata = {24'd0, o_kernel};
			`NN_REG_STRIDE: o_prdata = {24'd0, o_stride};
			`NN_REG_COUNT:  o_prdata = {24'd0, o_count};
			`NN_REG_BIAS:   o_prdata = {16'd0, o_bias};
			`NN_REG_STATUS: o_prdata = {30'd0, done, busy};
			`NN_REG_CYCLES: o_prdata = cycles;
			default:        mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_op     <= OP_NONE;
			o_kernel <= 8'd1;
			o_stride <= 8'd1;
			o_count  <= 8'd1;
			o_bias   <= 16'd0;
		end else if (wr_en) begin
			case (i_paddr)
				`NN_REG_CTRL:   if (!busy) o_op <= nn_op_e'(i_pwdata[1:0]);  // op locked mid-run
				`NN_REG_KERNEL: o_kernel <= i_pwdata[7:0];
				`NN_REG_STRIDE: o_stride <= i_pwdata[7:0];
				`NN_REG_COUNT:  o_count <= i_pwdata[7:0];
				`NN_REG_BIAS:   o_bias <= i_pwdata[15:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_start <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
			cycles  <= 32'd0;
		end else begin
			o_start <= start_req;
			if (start_req) begin
				busy   <= 1'b1;
				done   <= 1'b0;
				cycles <= 32'd0;
			end else begin
				if (i_done) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				if (busy)
					cycles <= cycles + 32'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/nn_engine_pkg.sv */
`default_nettype none

package nn_engine_pkg;

	// layer operation as written to CTRL[1:0]
	typedef enum logic [1:0] {
		OP_NONE    = 2'd0,
		OP_CONV    = 2'd1,
		OP_MAXPOOL = 2'd2,
		OP_AVEPOOL = 2'd3
	} nn_op_e;

	// window sequencer states
	typedef enum logic [1:0] {
		FS_IDLE  = 2'd0,
		FS_RUN   = 2'd1,  // issuing beats
		FS_FLUSH = 2'd2   // waiting for the last drain
	} feed_state_e;

endpackage

`default_nettype wire

/* logic/nn_engine_defs.svh */
`ifndef NN_ENGINE_DEFS_SVH
`define NN_ENGINE_DEFS_SVH

`define NN_LANES   4
`define NN_DW      16  // sample and weight width
`define NN_AW      32  // lane accumulator width
`define NN_ADDR_W  10

// apb register map
`define NN_REG_CTRL    8'h00
`define NN_REG_KERNEL  8'h04
`define NN_REG_STRIDE  8'h08
`define NN_REG_COUNT   8'h0C
`define NN_REG_BIAS    8'h10
`define NN_REG_STATUS  8'h14
`define NN_REG_CYCLES  8'h18

`endif
